/* include/k16_defs.svh */
`ifndef K16_DEFS_SVH
`define K16_DEFS_SVH

// Data path and instruction word width
`define K16_WORD_WIDTH 16

// Register file
`define K16_REG_COUNT 8
`define K16_REG_INDEX_WIDTH 3

// Decoded operations buffered between decoder and executor
`define K16_QUEUE_DEPTH 4

`endif

/* hw/k16Pkg.sv */
package k16Pkg;

  // Decoded operation codes
  // ADD..NOT follow instruction bits 2:0 of group 000
  typedef enum logic [4:0]
  {
    OP_ADD  = 5'd0,
    OP_ADC  = 5'd1,
    OP_SUB  = 5'd2,
    OP_SBC  = 5'd3,
    OP_AND  = 5'd4,
    OP_OR   = 5'd5,
    OP_XOR  = 5'd6,
    OP_NOT  = 5'd7,
    OP_INC  = 5'd8,
    OP_DEC  = 5'd9,
    OP_CMP  = 5'd10,
    OP_CLC  = 5'd11,
    OP_SEC  = 5'd12,
    OP_LDL  = 5'd13,
    OP_LDH  = 5'd14,
    OP_LDLZ = 5'd15,
    OP_LDHZ = 5'd16
  } k16OpT;

  // Executor sits in HOLD while a record waits on the output
  typedef enum logic
  {
    EXEC_IDLE = 1'b0,
    EXEC_HOLD = 1'b1
  } k16ExecStateT;

endpackage

/* hw/k16Decoder.sv */
`timescale 1ns/100ps
`include "k16_defs.svh"

module k16Decoder
(
  input  logic                            cpuInput1,
  input  logic                            reset,
  input  logic                            instrValid,
  input  logic [`K16_WORD_WIDTH-1:0]      instrWord,
  output logic                            instrReady,
  output logic                            opValid,
  output k16Pkg::k16OpT                   opCode,
  output logic [`K16_REG_INDEX_WIDTH-1:0] opDest,
  output logic [`K16_REG_INDEX_WIDTH-1:0] opSrcA,
  output logic [`K16_REG_INDEX_WIDTH-1:0] opSrcB,
  output logic [7:0]                      opImm,
  input  logic                            opReady
);

  logic          decSupported;
  k16Pkg::k16OpT decCode;
  logic          takeWord;

  // Output stage empty or being drained
  assign instrReady = !opValid || opReady;
  assign takeWord = instrValid && instrReady;

  always_comb
  begin
    decSupported = 1'b0;
    decCode = k16Pkg::OP_ADD;
    case (instrWord[15:13])
      3'b000:
      begin
        decSupported = 1'b1;
        casez (instrWord[3:0])
          4'b0???: decCode = k16Pkg::k16OpT'({2'b00, instrWord[2:0]});
          4'b1100: decCode = k16Pkg::OP_INC;
          4'b1110: decCode = k16Pkg::OP_CMP;
          4'b1111: decCode = k16Pkg::OP_DEC;
          default: decSupported = 1'b0;
        endcase
      end
      3'b001:
      begin
        decSupported = (instrWord[3:1] == 3'b100);
        decCode = instrWord[0] ? k16Pkg::OP_SEC : k16Pkg::OP_CLC;
      end
      3'b011:
      begin
        decSupported = 1'b1;
        case (instrWord[9:8])
          2'b00: decCode = k16Pkg::OP_LDL;
          2'b01: decCode = k16Pkg::OP_LDH;
          2'b10: decCode = k16Pkg::OP_LDLZ;
          default: decCode = k16Pkg::OP_LDHZ;
        endcase
      end
      default: decSupported = 1'b0;
    endcase
  end

  // Unsupported words are consumed and leave the stage empty
  always_ff @(posedge cpuInput1)
  begin
    if (reset)
      opValid <= 1'b0;
    else if (takeWord)
      opValid <= decSupported;
    else if (opReady)
      opValid <= 1'b0;
  end

  always_ff @(posedge cpuInput1)
  begin
    if (takeWord && decSupported)
    begin
      opCode <= decCode;
      opDest <= instrWord[12:10];
      opSrcA <= instrWord[9:7];
      opSrcB <= instrWord[6:4];
      opImm <= instrWord[7:0];
    end
  end

endmodule

/* hw/k16OpQueue.sv */
`timescale 1ns/100ps
`include "k16_defs.svh"

module k16OpQueue
#(
  parameter int Depth = `K16_QUEUE_DEPTH
)
(
  input  logic                            cpuInput1,
  input  logic                            reset,
  input  logic                            opValid,
  input  k16Pkg::k16OpT                   opCode,
  input  logic [`K16_REG_INDEX_WIDTH-1:0] opDest,
  input  logic [`K16_REG_INDEX_WIDTH-1:0] opSrcA,
  input  logic [`K16_REG_INDEX_WIDTH-1:0] opSrcB,
  input  logic [7:0]                      opImm,
  output logic                            opReady,
  output logic                            qValid,
  output k16Pkg::k16OpT                   qCode,
  output logic [`K16_REG_INDEX_WIDTH-1:0] qDest,
  output logic [`K16_REG_INDEX_WIDTH-1:0] qSrcA,
  output logic [`K16_REG_INDEX_WIDTH-1:0] qSrcB,
  output logic [7:0]                      qImm,
  input  logic                            qReady
);

  localparam int CodeWidth = $bits(k16Pkg::k16OpT);
  localparam int RegWidth = `K16_REG_INDEX_WIDTH;
  localparam int EntryWidth = CodeWidth + 3 * RegWidth + 8;
  localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CountWidth = $clog2(Depth + 1);

  logic [EntryWidth-1:0] entries [Depth];
  logic [EntryWidth-1:0] readEntry;
  logic [PtrWidth-1:0]   writePtr;
  logic [PtrWidth-1:0]   readPtr;
  logic [CountWidth-1:0] count;
  logic                  doWrite;
  logic                  doRead;

  function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(Depth - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  // Full queue still takes a write when the head leaves this cycle
  assign qValid = (count != '0);
  assign opReady = (count != CountWidth'(Depth)) || qReady;
  assign doWrite = opValid && opReady;
  assign doRead = qValid && qReady;

  always_ff @(posedge cpuInput1)
  begin
    if (reset)
    begin
      writePtr <= '0;
      readPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doWrite)
        writePtr <= nextPtr(writePtr);
      if (doRead)
        readPtr <= nextPtr(readPtr);
      case ({doWrite, doRead})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge cpuInput1)
  begin
    if (doWrite)
      entries[writePtr] <= {opCode, opDest, opSrcA, opSrcB, opImm};
  end

  assign readEntry = entries[readPtr];
  assign qCode = k16Pkg::k16OpT'(readEntry[EntryWidth-1 -: CodeWidth]);
  assign qDest = readEntry[8 + 2 * RegWidth +: RegWidth];
  assign qSrcA = readEntry[8 + RegWidth +: RegWidth];
  assign qSrcB = readEntry[8 +: RegWidth];
  assign qImm = readEntry[7:0];

endmodule

/* hw/k16Alu.sv */
`timescale 1ns/100ps
`include "k16_defs.svh"

module k16Alu
(
  input  k16Pkg::k16OpT               code,
  input  logic [`K16_WORD_WIDTH-1:0]  operandA,
  input  logic [`K16_WORD_WIDTH-1:0]  operandB,
  input  logic [7:0]                  imm,
  input  logic                        carryIn,
  output logic [`K16_WORD_WIDTH-1:0]  result,
  output logic                        carryOut
);

  localparam int W = `K16_WORD_WIDTH;

  logic [W:0] sum;
  logic       useCarry;

  assign useCarry = carryIn && (code == k16Pkg::OP_ADC || code == k16Pkg::OP_SBC);

  always_comb
  begin
    sum = '0;
    result = '0;
    carryOut = carryIn;
    case (code)
      k16Pkg::OP_ADD, k16Pkg::OP_ADC:
      begin
        sum = {1'b0, operandA} + {1'b0, operandB} + {{W{1'b0}}, useCarry};
        result = sum[W-1:0];
        carryOut = sum[W];
      end
      // Top bit of the wide difference is the borrow
      k16Pkg::OP_SUB, k16Pkg::OP_SBC, k16Pkg::OP_CMP:
      begin
        sum = {1'b0, operandA} - {1'b0, operandB} - {{W{1'b0}}, useCarry};
        result = sum[W-1:0];
        carryOut = sum[W];
      end
      k16Pkg::OP_AND: result = operandA & operandB;
      k16Pkg::OP_OR: result = operandA | operandB;
      k16Pkg::OP_XOR: result = operandA ^ operandB;
      k16Pkg::OP_NOT: result = ~operandA;
      k16Pkg::OP_INC: result = operandA + 1'b1;
      k16Pkg::OP_DEC: result = operandA - 1'b1;
      k16Pkg::OP_CLC: carryOut = 1'b0;
      k16Pkg::OP_SEC: carryOut = 1'b1;
      // Byte loads merge into the old destination value
      k16Pkg::OP_LDL: result = {operandA[W-1:8], imm};
      k16Pkg::OP_LDH: result = {imm, operandA[7:0]};
      k16Pkg::OP_LDLZ: result = {{(W-8){1'b0}}, imm};
      k16Pkg::OP_LDHZ: result = {imm, {(W-8){1'b0}}};
      default: result = '0;
    endcase
  end

endmodule

/* hw/k16Executor.sv */
`timescale 1ns/100ps
`include "k16_defs.svh"

module k16Executor
(
  input  logic                            cpuInput1,
  input  logic                            reset,
  input  logic                            qValid,
  input  k16Pkg::k16OpT                   qCode,
  input  logic [`K16_REG_INDEX_WIDTH-1:0] qDest,
  input  logic [`K16_REG_INDEX_WIDTH-1:0] qSrcA,
  input  logic [`K16_REG_INDEX_WIDTH-1:0] qSrcB,
  input  logic [7:0]                      qImm,
  output logic                            qReady,
  output logic                            resultValid,
  output logic                            resultWrite,
  output logic [`K16_REG_INDEX_WIDTH-1:0] resultDest,
  output logic [`K16_WORD_WIDTH-1:0]      resultData,
  output logic [2:0]                      resultFlags,
  input  logic                            resultReady
);

  k16Pkg::k16ExecStateT          state;
  logic [`K16_WORD_WIDTH-1:0]    regFile [`K16_REG_COUNT];
  logic                          carry;
  logic                          zero;
  logic                          negative;
  logic [`K16_WORD_WIDTH-1:0]    operandA;
  logic [`K16_WORD_WIDTH-1:0]    operandB;
  logic [`K16_WORD_WIDTH-1:0]    aluResult;
  logic                          aluCarry;
  logic                          isLoad;
  logic                          writesReg;
  logic                          keepsZn;
  logic                          nextZero;
  logic                          nextNegative;
  logic                          consume;

  // A held record blocks the queue until it is taken
  assign qReady = (state == k16Pkg::EXEC_IDLE) || resultReady;
  assign resultValid = (state == k16Pkg::EXEC_HOLD);
  assign consume = qValid && qReady;

  assign isLoad = qCode inside {k16Pkg::OP_LDL, k16Pkg::OP_LDH, k16Pkg::OP_LDLZ, k16Pkg::OP_LDHZ};
  assign writesReg = !(qCode inside {k16Pkg::OP_CMP, k16Pkg::OP_CLC, k16Pkg::OP_SEC});
  assign keepsZn = qCode inside {k16Pkg::OP_CLC, k16Pkg::OP_SEC};

  assign operandA = isLoad ? regFile[qDest] : regFile[qSrcA];
  assign operandB = regFile[qSrcB];

  k16Alu alu
  (
    .code(qCode),
    .operandA(operandA),
    .operandB(operandB),
    .imm(qImm),
    .carryIn(carry),
    .result(aluResult),
    .carryOut(aluCarry)
  );

  assign nextZero = keepsZn ? zero : (aluResult == '0);
  assign nextNegative = keepsZn ? negative : aluResult[`K16_WORD_WIDTH-1];

  always_ff @(posedge cpuInput1)
  begin
    if (reset)
      state <= k16Pkg::EXEC_IDLE;
    else if (consume)
      state <= k16Pkg::EXEC_HOLD;
    else if (resultReady)
      state <= k16Pkg::EXEC_IDLE;
  end

  always_ff @(posedge cpuInput1)
  begin
    if (reset)
    begin
      for (int i = 0; i < `K16_REG_COUNT; i++)
        regFile[i] <= '0;
      carry <= 1'b0;
      zero <= 1'b0;
      negative <= 1'b0;
    end
    else if (consume)
    begin
      if (writesReg)
        regFile[qDest] <= aluResult;
      carry <= aluCarry;
      zero <= nextZero;
      negative <= nextNegative;
    end
  end

  // Record carries the flags as they stand after the operation
  always_ff @(posedge cpuInput1)
  begin
    if (consume)
    begin
      resultWrite <= writesReg;
      resultDest <= qDest;
      resultData <= aluResult;
      resultFlags <= {aluCarry, nextZero, nextNegative};
    end
  end

endmodule

/* hw/k16Core.sv */
`timescale 1ns/100ps
`include "k16_defs.svh"

module k16Core
(
  input  logic                            cpuInput1,
  input  logic                            reset,
  input  logic                            instrValid,
  input  logic [`K16_WORD_WIDTH-1:0]      instrWord,
  output logic                            instrReady,
  output logic                            resultValid,
  output logic                            resultWrite,
  output logic [`K16_REG_INDEX_WIDTH-1:0] resultDest,
  output logic [`K16_WORD_WIDTH-1:0]      resultData,
  output logic [2:0]                      resultFlags,
  input  logic                            resultReady
);

  // Decoder to queue
  logic                            opValid;
  k16Pkg::k16OpT                   opCode;
  logic [`K16_REG_INDEX_WIDTH-1:0] opDest;
  logic [`K16_REG_INDEX_WIDTH-1:0] opSrcA;
  logic [`K16_REG_INDEX_WIDTH-1:0] opSrcB;
  logic [7:0]                      opImm;
  logic                            opReady;

  // Queue to executor
  logic                            qValid;
  k16Pkg::k16OpT                   qCode;
  logic [`K16_REG_INDEX_WIDTH-1:0] qDest;
  logic [`K16_REG_INDEX_WIDTH-1:0] qSrcA;
  logic [`K16_REG_INDEX_WIDTH-1:0] qSrcB;
  logic [7:0]                      qImm;
  logic                            qReady;

  k16Decoder decoder (.*);

  k16OpQueue #(.Depth(`K16_QUEUE_DEPTH)) opQueue (.*);

  k16Executor executor (.*);

endmodule

/* tests/k16Checker.sv */
`timescale 1ns/100ps
`include "k16_defs.svh"

module k16Checker
(
  input  logic                            cpuInput1,
  input  logic                            reset,
  input  logic                            instrValid,
  input  logic [`K16_WORD_WIDTH-1:0]      instrWord,
  input  logic                            instrReady,
  input  logic                            resultValid,
  input  logic                            resultWrite,
  input  logic [`K16_REG_INDEX_WIDTH-1:0] resultDest,
  input  logic [`K16_WORD_WIDTH-1:0]      resultData,
  input  logic [2:0]                      resultFlags,
  input  logic                            resultReady,
  output int                              errorCount,
  output int                              pendingCount,
  output int                              acceptedCount,
  output int                              checkedCount
);

  // Record layout is write, dest, data, then carry, zero, negative
  logic [15:0] regs [`K16_REG_COUNT];
  logic        modelCarry;
  logic        modelZero;
  logic        modelNegative;
  logic [22:0] expected [$];

  task automatic reportMismatch(input string field, input logic [15:0] expVal,
                                input logic [15:0] gotVal);
    errorCount++;
    $display("Error at %0t: record %0d %s expected %h got %h", $time, checkedCount, field,
             expVal, gotVal);
  endtask

  task automatic applyWord(input logic [15:0] w);
    logic [3:0]  low;
    logic [2:0]  d;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] res;
    logic        kept;
    logic        wr;
    logic        keepZn;
    logic        c;
    int          wide;
    low = w[3:0];
    d = w[12:10];
    a = regs[w[9:7]];
    b = regs[w[6:4]];
    res = '0;
    kept = 1'b1;
    wr = 1'b1;
    keepZn = 1'b0;
    c = modelCarry;
    case (w[15:13])
      3'b000:
        if (!low[3])
        begin
          case (low[2:0])
            3'd0, 3'd1:
            begin
              wide = int'(a) + int'(b) + (low[0] ? int'(modelCarry) : 0);
              res = wide[15:0];
              c = (wide > 65535);
            end
            // Borrow when the true difference goes negative
            3'd2, 3'd3:
            begin
              wide = int'(a) - int'(b) - (low[0] ? int'(modelCarry) : 0);
              res = wide[15:0];
              c = (wide < 0);
            end
            3'd4: res = a & b;
            3'd5: res = a | b;
            3'd6: res = a ^ b;
            default: res = ~a;
          endcase
        end
        else if (low == 4'b1100)
          res = a + 16'd1;
        else if (low == 4'b1111)
          res = a - 16'd1;
        else if (low == 4'b1110)
        begin
          wide = int'(a) - int'(b);
          res = wide[15:0];
          c = (wide < 0);
          wr = 1'b0;
        end
        else
          kept = 1'b0;
      3'b001:
        if (low == 4'b1000 || low == 4'b1001)
        begin
          c = low[0];
          wr = 1'b0;
          keepZn = 1'b1;
        end
        else
          kept = 1'b0;
      3'b011:
        case (w[9:8])
          2'd0: res = {regs[d][15:8], w[7:0]};
          2'd1: res = {w[7:0], regs[d][7:0]};
          2'd2: res = {8'h00, w[7:0]};
          default: res = {w[7:0], 8'h00};
        endcase
      default: kept = 1'b0;
    endcase
    if (kept)
    begin
      if (!keepZn)
      begin
        modelZero = (res == 16'h0000);
        modelNegative = res[15];
      end
      modelCarry = c;
      if (wr)
        regs[d] = res;
      expected.push_back({wr, d, res, modelCarry, modelZero, modelNegative});
    end
  endtask

  task automatic compareRecord();
    logic [22:0] rec;
    if (expected.size() == 0)
    begin
      errorCount++;
      $display("Error at %0t: a record arrived with no instruction left to match it", $time);
    end
    else
    begin
      rec = expected.pop_front();
      if (resultWrite !== rec[22])
        reportMismatch("resultWrite", rec[22], resultWrite);
      if (rec[22] && resultDest !== rec[21:19])
        reportMismatch("resultDest", rec[21:19], resultDest);
      if (resultData !== rec[18:3])
        reportMismatch("resultData", rec[18:3], resultData);
      if (resultFlags !== rec[2:0])
        reportMismatch("resultFlags", rec[2:0], resultFlags);
      checkedCount++;
    end
  endtask

  initial
  begin
    errorCount = 0;
    pendingCount = 0;
    acceptedCount = 0;
    checkedCount = 0;
  end

  always @(posedge cpuInput1)
  begin
    if (reset)
    begin
      for (int i = 0; i < `K16_REG_COUNT; i++)
        regs[i] = '0;
      modelCarry = 1'b0;
      modelZero = 1'b0;
      modelNegative = 1'b0;
      expected.delete();
    end
    else
    begin
      if (resultValid && resultReady)
        compareRecord();
      if (instrValid && instrReady)
      begin
        acceptedCount++;
        applyWord(instrWord);
      end
    end
    pendingCount = expected.size();
  end

endmodule

/* tests/k16Core_assertions.sv */
`timescale 1ns/100ps
`include "k16_defs.svh"

module k16CoreAssertions
(
  input logic                            cpuInput1,
  input logic                            reset,
  input logic                            resultValid,
  input logic                            resultReady,
  input logic                            resultWrite,
  input logic [`K16_REG_INDEX_WIDTH-1:0] resultDest,
  input logic [`K16_WORD_WIDTH-1:0]      resultData,
  input logic [2:0]                      resultFlags,
  input logic                            opValid,
  input logic                            opReady,
  input k16Pkg::k16OpT                   opCode,
  input logic [`K16_REG_INDEX_WIDTH-1:0] opDest,
  input logic [`K16_REG_INDEX_WIDTH-1:0] opSrcA,
  input logic [`K16_REG_INDEX_WIDTH-1:0] opSrcB,
  input logic [7:0]                      opImm
);

  int failCount = 0;

  // Stalled record keeps every field
  recordHeld: assert property (@(posedge cpuInput1) disable iff (reset)
    resultValid && !resultReady |=>
      resultValid && $stable({resultWrite, resultDest, resultData, resultFlags}))
    else
    begin
      $error("Result record changed while resultReady was low");
      failCount++;
    end

  opHeld: assert property (@(posedge cpuInput1) disable iff (reset)
    opValid && !opReady |=> opValid && $stable({opCode, opDest, opSrcA, opSrcB, opImm}))
    else
    begin
      $error("Decoded operation changed before the queue took it");
      failCount++;
    end

  resetClears: assert property (@(posedge cpuInput1) reset |=> !resultValid)
    else
    begin
      $error("resultValid was high in the cycle after reset");
      failCount++;
    end

endmodule

bind k16Core k16CoreAssertions coreAssertions (.*);

/* tests/k16CoreTb.sv */
`timescale 1ns/100ps
`include "k16_defs.svh"

module k16CoreTb;

  localparam int NumWords = 400;
  localparam int TimeoutCycles = NumWords * 8 + 100;

  logic                            cpuInput1;
  logic                            reset;
  logic                            instrValid;
  logic [`K16_WORD_WIDTH-1:0]      instrWord;
  logic                            instrReady;
  logic                            resultValid;
  logic                            resultWrite;
  logic [`K16_REG_INDEX_WIDTH-1:0] resultDest;
  logic [`K16_WORD_WIDTH-1:0]      resultData;
  logic [2:0]                      resultFlags;
  logic                            resultReady;
  int                              errorCount;
  int                              pendingCount;
  int                              acceptedCount;
  int                              checkedCount;
  int                              cycleCount;
  logic [31:0]                     lfsrState = 32'hff242752;

  k16Core i_dut (.*);

  k16Checker recordCheck (.*);

  // Galois LFSR stepped once per bit handed out
  function automatic logic [31:0] randomBits(input int count);
    logic [31:0] value;
    logic        outBit;
    value = '0;
    for (int i = 0; i < count; i++)
    begin
      outBit = lfsrState[0];
      lfsrState = lfsrState >> 1;
      if (outBit)
        lfsrState = lfsrState ^ 32'h80200003;
      value = {value[30:0], outBit};
    end
    return value;
  endfunction

  function automatic logic [15:0] makeWord();
    logic [15:0] word;
    logic [3:0]  kind;
    word = randomBits(16);
    kind = randomBits(4);
    if (randomBits(3) == 0)
    begin
      // Roughly one word in eight falls outside the kept set
      case (randomBits(2))
        2'd0: word[15:13] = 3'b000;
        2'd1: word[15:13] = 3'b010;
        2'd2: word[15:13] = 3'b001;
        default: word[15] = 1'b1;
      endcase
      if (word[15:13] == 3'b000)
        word[3:0] = (word[4]) ? 4'b1101 : {2'b10, word[1:0]};
      else if (word[15:13] == 3'b001)
        word[3] = 1'b0;
    end
    else if (kind < 8)
    begin
      word[15:13] = 3'b000;
      word[3:0] = {1'b0, kind[2:0]};
    end
    else if (kind < 11)
    begin
      word[15:13] = 3'b000;
      word[3:0] = (kind == 8) ? 4'b1100 : (kind == 9) ? 4'b1111 : 4'b1110;
    end
    else if (kind < 13)
    begin
      word[15:13] = 3'b001;
      word[3:0] = {3'b100, kind[0]};
    end
    else
      word[15:13] = 3'b011;
    return word;
  endfunction

  task automatic printSummary();
    $display(
      "Summary: %0d accepted, %0d checked, %0d errors, %0d missing, %0d assertion failures",
      acceptedCount, checkedCount, errorCount, pendingCount, i_dut.coreAssertions.failCount);
  endtask

  initial
  begin
    cpuInput1 = 1'b0;
    forever #4 cpuInput1 = ~cpuInput1;
  end

  initial
  begin
    cycleCount = 0;
    while (cycleCount < TimeoutCycles)
    begin
      @(posedge cpuInput1);
      cycleCount++;
    end
    $display("Timeout after %0d cycles, results were missing from the output", cycleCount);
    printSummary();
    $display("** FAIL **");
    $finish;
  end

  initial
  begin
    int   sent;
    logic taken;
    sent = 0;
    reset = 1'b1;
    instrValid = 1'b0;
    instrWord = '0;
    resultReady = 1'b1;
    repeat (4) @(posedge cpuInput1);
    #1;
    reset = 1'b0;
    while (sent < NumWords)
    begin
      resultReady = (randomBits(3) >= 3);
      if (!instrValid && randomBits(2) != 0)
      begin
        instrValid = 1'b1;
        instrWord = makeWord();
      end
      // Ready is settled by the falling edge
      @(negedge cpuInput1);
      taken = instrValid && instrReady;
      @(posedge cpuInput1);
      #1;
      if (taken)
      begin
        sent++;
        instrValid = 1'b0;
      end
    end
    resultReady = 1'b1;
    while (pendingCount != 0)
    begin
      @(posedge cpuInput1);
      #1;
    end
    // A few idle cycles to catch stray records
    repeat (4) @(posedge cpuInput1);
    #1;
    printSummary();
    if (errorCount == 0 && pendingCount == 0 && acceptedCount == NumWords &&
        i_dut.coreAssertions.failCount == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

/* sim.f */
+incdir+include
hw/k16Pkg.sv
hw/k16Decoder.sv
hw/k16OpQueue.sv
hw/k16Alu.sv
hw/k16Executor.sv
hw/k16Core.sv
tests/k16Checker.sv
tests/k16Core_assertions.sv
tests/k16CoreTb.sv

/* Bender.yml */
package:
  name: k16_core

sources:
  - include_dirs:
      - include
    files:
      - hw/k16Pkg.sv
      - hw/k16Decoder.sv
      - hw/k16OpQueue.sv
      - hw/k16Alu.sv
      - hw/k16Executor.sv
      - hw/k16Core.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/k16Checker.sv
      - tests/k16Core_assertions.sv
      - tests/k16CoreTb.sv
